//--- Bender.yml
package:
  name: i2c_avl_bridge

sources:
  - include_dirs:
      - logic
    files:
      - logic/bridge_pkg.sv
      - logic/addr_tracker.sv
      - logic/xfer_sequencer.sv
      - logic/i2c_avl_bridge.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/avl_mem_model.sv
      - test/tb_i2c_avl_bridge.sv

//--- all.f
+incdir+logic
logic/bridge_pkg.sv
logic/addr_tracker.sv
logic/xfer_sequencer.sv
logic/i2c_avl_bridge.sv
test/avl_mem_model.sv
test/tb_i2c_avl_bridge.sv

//--- logic/addr_tracker.sv
/*
 * Address tracker
 * assembles the two-byte word address and runs the
 * auto-incrementing counter that drives the Avalon address
 */
`include "bridge_cfg.svh"
`default_nettype none

module addr_tracker import bridge_pkg::*; (
  input  wire                    i2c_clk,
  input  wire                    i2c_rst_n,
  input  wire [`BYTE_W-1:0]      rx_byte,
  input  wire                    addr_hi_wr,
  input  wire                    addr_lo_wr,
  input  wire                    addr_commit,
  input  wire                    addr_incr,
  output logic [`AVL_ADDR_W-1:0] avl_addr
);

  word_addr_t addr_asm;
  word_addr_t addr_cnt;

  // high byte clears the low half, so a lone first byte
  // commits as {hi, 8'h00}
  always_ff @(posedge i2c_clk) begin
    if (addr_hi_wr) begin
      addr_asm <= {rx_byte, {`BYTE_W{1'b0}}};
    end else if (addr_lo_wr) begin
      addr_asm[`BYTE_W-1:0] <= rx_byte;
    end
  end

  always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
    if (!i2c_rst_n) begin
      addr_cnt <= '0;
    end else if (addr_commit) begin
      addr_cnt <= addr_asm;
    end else if (addr_incr) begin
      // wraps at the top of the word address space
      addr_cnt <= addr_cnt + 1'b1;
    end
  end

  assign avl_addr = {{(`AVL_ADDR_W-`WORD_ADDR_W){1'b0}}, addr_cnt};

  // a load and an increment in one cycle would lose one of them
  a_no_commit_incr: assert property (
    @(posedge i2c_clk) disable iff (!i2c_rst_n)
    !(addr_commit && addr_incr)
  );

endmodule

`default_nettype wire

//--- logic/bridge_cfg.svh
/*
 * I2C to Avalon bridge widths
 * byte, word address and Avalon bus sizes shared by all blocks
 */
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// I2C side
`define BYTE_W       8
`define WORD_ADDR_W  16

// Avalon master side
`define AVL_ADDR_W   32
`define AVL_DATA_W   32
`define AVL_BE_W     4

`endif

//--- logic/bridge_pkg.sv
/*
 * I2C to Avalon bridge types
 * word address type and the transfer sequencer state encoding
 */
`include "bridge_cfg.svh"
`default_nettype none

package bridge_pkg;

  // two address bytes, high byte first on the wire
  typedef logic [`WORD_ADDR_W-1:0] word_addr_t;

  typedef enum logic [2:0] {
    st_idle,
    // first address byte taken
    st_addr_hi,
    // address complete, counter loads
    st_addr_commit,
    st_wr_wait,
    // avl_write held until accepted
    st_wr_issue,
    // avl_read held until accepted
    st_rd_issue,
    // waiting for read data and next master ack
    st_rd_data
  } xfer_state_e;

endpackage

`default_nettype wire

//--- logic/i2c_avl_bridge.sv
/*
 * I2C slave to Avalon master bridge
 * sequencer drives the bus commands, tracker owns the word address
 */
`include "bridge_cfg.svh"
`default_nettype none

module i2c_avl_bridge (
  input  wire                    i2c_clk,
  input  wire                    i2c_rst_n,
  // I2C slave front end
  input  wire                    put_rx_databuffer,
  input  wire                    set_rd_req,
  input  wire                    stop_det,
  input  wire                    start_det,
  input  wire                    slv_tx_chk_ack,
  input  wire                    ack_det,
  input  wire [`BYTE_W-1:0]      rdata_rx_databuffer,
  output wire [`BYTE_W-1:0]      readdatabyte,
  output wire                    avl_readdatavalid_reg,
  // Avalon master
  input  wire                    waitrequest,
  input  wire [`AVL_DATA_W-1:0]  avl_readdata,
  input  wire                    avl_readdatavalid,
  output wire                    avl_read,
  output wire                    avl_write,
  output wire [`AVL_ADDR_W-1:0]  avl_addr,
  output wire [`AVL_DATA_W-1:0]  avl_writedata,
  output wire [`AVL_BE_W-1:0]    avl_byteenable
);

  logic addr_hi_wr;
  logic addr_lo_wr;
  logic addr_commit;
  logic addr_incr;

  xfer_sequencer u_seq (
    .i2c_clk               (i2c_clk),
    .i2c_rst_n             (i2c_rst_n),
    .put_rx_databuffer     (put_rx_databuffer),
    .set_rd_req            (set_rd_req),
    .stop_det              (stop_det),
    .start_det             (start_det),
    .slv_tx_chk_ack        (slv_tx_chk_ack),
    .ack_det               (ack_det),
    .waitrequest           (waitrequest),
    .avl_readdatavalid     (avl_readdatavalid),
    .rdata_rx_databuffer   (rdata_rx_databuffer),
    .avl_readdata          (avl_readdata),
    .addr_hi_wr            (addr_hi_wr),
    .addr_lo_wr            (addr_lo_wr),
    .addr_commit           (addr_commit),
    .addr_incr             (addr_incr),
    .avl_read              (avl_read),
    .avl_write             (avl_write),
    .avl_writedata         (avl_writedata),
    .avl_byteenable        (avl_byteenable),
    .readdatabyte          (readdatabyte),
    .avl_readdatavalid_reg (avl_readdatavalid_reg)
  );

  // address bytes come straight from the receive buffer
  addr_tracker u_addr (
    .i2c_clk     (i2c_clk),
    .i2c_rst_n   (i2c_rst_n),
    .rx_byte     (rdata_rx_databuffer),
    .addr_hi_wr  (addr_hi_wr),
    .addr_lo_wr  (addr_lo_wr),
    .addr_commit (addr_commit),
    .addr_incr   (addr_incr),
    .avl_addr    (avl_addr)
  );

endmodule

`default_nettype wire

//--- logic/xfer_sequencer.sv
/*
 * Transfer sequencer
 * collects the word address bytes, then turns received bytes into
 * Avalon writes and read requests or master acks into Avalon reads
 */
`include "bridge_cfg.svh"
`default_nettype none

module xfer_sequencer import bridge_pkg::*; (
  input  wire                    i2c_clk,
  input  wire                    i2c_rst_n,
  input  wire                    put_rx_databuffer,
  input  wire                    set_rd_req,
  input  wire                    stop_det,
  input  wire                    start_det,
  input  wire                    slv_tx_chk_ack,
  input  wire                    ack_det,
  input  wire                    waitrequest,
  input  wire                    avl_readdatavalid,
  input  wire [`BYTE_W-1:0]      rdata_rx_databuffer,
  input  wire [`AVL_DATA_W-1:0]  avl_readdata,
  output logic                   addr_hi_wr,
  output logic                   addr_lo_wr,
  output logic                   addr_commit,
  output logic                   addr_incr,
  output logic                   avl_read,
  output logic                   avl_write,
  output logic [`AVL_DATA_W-1:0] avl_writedata,
  output logic [`AVL_BE_W-1:0]   avl_byteenable,
  output logic [`BYTE_W-1:0]     readdatabyte,
  output logic                   avl_readdatavalid_reg
);

  xfer_state_e        state;
  xfer_state_e        state_nxt;
  logic               ack_det_q;
  logic               ack_rise;
  logic               end_req;
  logic               end_pending;
  logic               addr_full;
  logic               held;
  logic               wr_done;
  logic [`BYTE_W-1:0] wr_byte;

  // stop or repeated start
  assign end_req  = stop_det | start_det;
  assign ack_rise = ack_det & ~ack_det_q;
  assign held     = avl_read | avl_write;

  assign addr_hi_wr  = (state == st_idle) & put_rx_databuffer;
  assign addr_lo_wr  = (state == st_addr_hi) & put_rx_databuffer & ~end_req;
  assign addr_commit = (state == st_addr_commit);
  assign addr_incr   = wr_done | avl_readdatavalid_reg;

  assign avl_write      = (state == st_wr_issue);
  assign avl_read       = (state == st_rd_issue);
  assign avl_byteenable = {`AVL_BE_W{held}};
  assign avl_writedata  = {{(`AVL_DATA_W-`BYTE_W){1'b0}}, wr_byte};

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (put_rx_databuffer) begin
          state_nxt = st_addr_hi;
        end else if (set_rd_req) begin
          state_nxt = st_rd_issue;
        end
      end
      st_addr_hi: begin
        if (end_req || put_rx_databuffer) begin
          state_nxt = st_addr_commit;
        end
      end
      st_addr_commit: begin
        // partial address just loads the counter
        if (addr_full && !end_req) begin
          state_nxt = st_wr_wait;
        end else begin
          state_nxt = st_idle;
        end
      end
      st_wr_wait: begin
        if (end_req) begin
          state_nxt = st_idle;
        end else if (put_rx_databuffer) begin
          state_nxt = st_wr_issue;
        end
      end
      st_wr_issue: begin
        if (!waitrequest) begin
          state_nxt = (end_pending || end_req) ? st_idle : st_wr_wait;
        end
      end
      st_rd_issue: begin
        if (!waitrequest) begin
          state_nxt = (end_pending || end_req) ? st_idle : st_rd_data;
        end
      end
      st_rd_data: begin
        if (end_req) begin
          state_nxt = st_idle;
        end else if (slv_tx_chk_ack && ack_rise) begin
          state_nxt = st_rd_issue;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
    if (!i2c_rst_n) begin
      state                 <= st_idle;
      ack_det_q             <= 1'b0;
      end_pending           <= 1'b0;
      addr_full             <= 1'b0;
      wr_done               <= 1'b0;
      readdatabyte          <= '0;
      avl_readdatavalid_reg <= 1'b0;
    end else begin
      state                 <= state_nxt;
      ack_det_q             <= ack_det;
      // stop seen while a command waits, end once it is taken
      end_pending           <= held & waitrequest & (end_pending | end_req);
      addr_full             <= addr_lo_wr;
      wr_done               <= avl_write & ~waitrequest;
      avl_readdatavalid_reg <= avl_readdatavalid;
      if (avl_readdatavalid) begin
        readdatabyte <= avl_readdata[`BYTE_W-1:0];
      end
    end
  end

  // data byte for the next write
  always_ff @(posedge i2c_clk) begin
    if (state == st_wr_wait && state_nxt == st_wr_issue) begin
      wr_byte <= rdata_rx_databuffer;
    end
  end

  a_one_cmd: assert property (
    @(posedge i2c_clk) disable iff (!i2c_rst_n)
    !(avl_read && avl_write)
  );

  // command frozen under back-pressure
  a_cmd_stable: assert property (
    @(posedge i2c_clk) disable iff (!i2c_rst_n)
    held && waitrequest |=>
      $stable({avl_read, avl_write, avl_writedata, avl_byteenable})
  );

endmodule

`default_nettype wire

//--- test/avl_mem_model.sv
/*
 * Avalon slave memory model
 * random waitrequest, read data one cycle after acceptance,
 * and a log of every accepted read and write
 */
`include "bridge_cfg.svh"
`default_nettype none

module avl_mem_model (
  input  wire                    i2c_clk,
  input  wire                    i2c_rst_n,
  input  wire                    avl_read,
  input  wire                    avl_write,
  input  wire [`AVL_ADDR_W-1:0]  avl_addr,
  input  wire [`AVL_DATA_W-1:0]  avl_writedata,
  input  wire [`AVL_BE_W-1:0]    avl_byteenable,
  output logic                   waitrequest,
  output logic [`AVL_DATA_W-1:0] avl_readdata,
  output logic                   avl_readdatavalid
);
  timeunit 1ns;
  timeprecision 100ps;

  // 256 words, indexed by the low address byte
  logic [`AVL_DATA_W-1:0] mem [0:255];
  logic [`AVL_ADDR_W-1:0] wr_log_addr [0:63];
  logic [`AVL_DATA_W-1:0] wr_log_data [0:63];
  logic [`AVL_BE_W-1:0]   wr_log_be   [0:63];
  logic [`AVL_ADDR_W-1:0] rd_log_addr [0:63];
  int                     wr_count;
  int                     rd_count;
  integer                 seed;
  logic [31:0]            rnd;

  initial begin
    seed              = 68;
    wr_count          = 0;
    rd_count          = 0;
    waitrequest       = 1'b1;
    avl_readdata      = '0;
    avl_readdatavalid = 1'b0;
    // every word differs, all index bits count
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'hA5, (i[7:0] * 8'd7) ^ 8'h3C};
    end
  end

  always @(posedge i2c_clk or negedge i2c_rst_n) begin
    if (!i2c_rst_n) begin
      waitrequest       <= 1'b1;
      avl_readdatavalid <= 1'b0;
    end else begin
      rnd = $random(seed);
      waitrequest       <= #1 rnd[0];
      avl_readdatavalid <= #1 avl_read & ~waitrequest;
      if (avl_read && !waitrequest) begin
        avl_readdata          <= #1 mem[avl_addr[7:0]];
        rd_log_addr[rd_count] <= avl_addr;
        rd_count              <= rd_count + 1;
      end
      if (avl_write && !waitrequest) begin
        mem[avl_addr[7:0]]    <= avl_writedata;
        wr_log_addr[wr_count] <= avl_addr;
        wr_log_data[wr_count] <= avl_writedata;
        wr_log_be[wr_count]   <= avl_byteenable;
        wr_count              <= wr_count + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_i2c_avl_bridge.sv
/*
 * Testbench for the I2C to Avalon bridge
 * directed address, write, read and stop tests against a memory model
 */
`include "bridge_cfg.svh"
`default_nettype none

module tb_i2c_avl_bridge import bridge_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // tests take a few hundred cycles even with long stalls
  localparam int cycle_limit = 3000;

  logic                   i2c_clk;
  logic                   i2c_rst_n;
  logic                   put_rx_databuffer;
  logic                   set_rd_req;
  logic                   stop_det;
  logic                   start_det;
  logic                   slv_tx_chk_ack;
  logic                   ack_det;
  logic [`BYTE_W-1:0]     rdata_rx_databuffer;
  wire  [`BYTE_W-1:0]     readdatabyte;
  wire                    avl_readdatavalid_reg;
  wire                    waitrequest;
  wire  [`AVL_DATA_W-1:0] avl_readdata;
  wire                    avl_readdatavalid;
  wire                    avl_read;
  wire                    avl_write;
  wire  [`AVL_ADDR_W-1:0] avl_addr;
  wire  [`AVL_DATA_W-1:0] avl_writedata;
  wire  [`AVL_BE_W-1:0]   avl_byteenable;

  int                     errors;
  int                     checks;
  int                     cycles = 0;
  logic [15:0]            exp_addr;
  xfer_state_e            stuck_state;

  i2c_avl_bridge DUT (
    .i2c_clk               (i2c_clk),
    .i2c_rst_n             (i2c_rst_n),
    .put_rx_databuffer     (put_rx_databuffer),
    .set_rd_req            (set_rd_req),
    .stop_det              (stop_det),
    .start_det             (start_det),
    .slv_tx_chk_ack        (slv_tx_chk_ack),
    .ack_det               (ack_det),
    .rdata_rx_databuffer   (rdata_rx_databuffer),
    .readdatabyte          (readdatabyte),
    .avl_readdatavalid_reg (avl_readdatavalid_reg),
    .waitrequest           (waitrequest),
    .avl_readdata          (avl_readdata),
    .avl_readdatavalid     (avl_readdatavalid),
    .avl_read              (avl_read),
    .avl_write             (avl_write),
    .avl_addr              (avl_addr),
    .avl_writedata         (avl_writedata),
    .avl_byteenable        (avl_byteenable)
  );

  avl_mem_model mem_model (
    .i2c_clk           (i2c_clk),
    .i2c_rst_n         (i2c_rst_n),
    .avl_read          (avl_read),
    .avl_write         (avl_write),
    .avl_addr          (avl_addr),
    .avl_writedata     (avl_writedata),
    .avl_byteenable    (avl_byteenable),
    .waitrequest       (waitrequest),
    .avl_readdata      (avl_readdata),
    .avl_readdatavalid (avl_readdatavalid)
  );

  initial begin
    i2c_clk = 1'b0;
    forever #2 i2c_clk = ~i2c_clk;
  end

  always @(posedge i2c_clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      stuck_state = DUT.u_seq.state;
      $display("timeout: run still busy after %0d cycles, sequencer in %s",
               cycles, stuck_state.name());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // step to just after the next rising edge
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge i2c_clk);
      #1;
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    rdata_rx_databuffer = b;
    put_rx_databuffer   = 1'b1;
    tick(1);
    put_rx_databuffer   = 1'b0;
    tick(2);
  endtask

  task automatic end_sequence(input logic repeated);
    if (repeated) begin
      start_det = 1'b1;
    end else begin
      stop_det = 1'b1;
    end
    tick(1);
    start_det = 1'b0;
    stop_det  = 1'b0;
    tick(2);
  endtask

  task automatic write_and_check(input logic [7:0] b);
    int base;
    base = mem_model.wr_count;
    send_byte(b);
    while (avl_write) begin
      tick(1);
    end
    // counter steps the cycle after acceptance
    tick(1);
    check_val("write count", mem_model.wr_count, base + 1);
    check_val("avl_addr", mem_model.wr_log_addr[base], 32'(exp_addr));
    check_val("avl_writedata", mem_model.wr_log_data[base], {24'h0, b});
    check_val("avl_byteenable", mem_model.wr_log_be[base], 4'hF);
    exp_addr++;
  endtask

  task automatic read_and_check(input logic by_ack, input logic [7:0] exp_byte);
    int base;
    base = mem_model.rd_count;
    if (by_ack) begin
      ack_det = 1'b1;
      tick(1);
      ack_det = 1'b0;
    end else begin
      set_rd_req = 1'b1;
      tick(1);
      set_rd_req = 1'b0;
    end
    while (!avl_readdatavalid_reg) begin
      tick(1);
    end
    check_val("readdatabyte", readdatabyte, exp_byte);
    check_val("read count", mem_model.rd_count, base + 1);
    check_val("avl_addr", mem_model.rd_log_addr[base], 32'(exp_addr));
    exp_addr++;
  endtask

  task automatic idle_after_reset;
    check_val("avl_read", avl_read, 1'b0);
    check_val("avl_write", avl_write, 1'b0);
    check_val("avl_readdatavalid_reg", avl_readdatavalid_reg, 1'b0);
    check_val("avl_byteenable", avl_byteenable, '0);
    check_val("readdatabyte", readdatabyte, '0);
  endtask

  task automatic addr_then_writes;
    exp_addr = 16'h1234;
    send_byte(8'h12);
    send_byte(8'h34);
    write_and_check(8'hA1);
    write_and_check(8'hB2);
    write_and_check(8'hC3);
    end_sequence(1'b0);
  endtask

  task automatic random_read;
    exp_addr = 16'h1234;
    send_byte(8'h12);
    send_byte(8'h34);
    end_sequence(1'b1);
    read_and_check(1'b0, 8'hA1);
  endtask

  task automatic sequential_reads;
    slv_tx_chk_ack = 1'b1;
    read_and_check(1'b1, 8'hB2);
    read_and_check(1'b1, 8'hC3);
    // initial memory contents past the written bytes
    read_and_check(1'b1, mem_model.mem[8'h37][7:0]);
    end_sequence(1'b0);
  endtask

  task automatic partial_addr_read;
    exp_addr = 16'h0500;
    send_byte(8'h05);
    end_sequence(1'b0);
    read_and_check(1'b0, mem_model.mem[8'h00][7:0]);
  endtask

  task automatic stop_during_reads;
    int base;
    slv_tx_chk_ack = 1'b1;
    read_and_check(1'b1, mem_model.mem[8'h01][7:0]);
    end_sequence(1'b0);
    base    = mem_model.rd_count;
    ack_det = 1'b1;
    tick(1);
    ack_det = 1'b0;
    repeat (10) begin
      check_val("avl_read", avl_read, 1'b0);
      tick(1);
    end
    check_val("read count", mem_model.rd_count, base);
    slv_tx_chk_ack = 1'b0;
  endtask

  initial begin
    errors              = 0;
    checks              = 0;
    exp_addr            = '0;
    i2c_rst_n           = 1'b0;
    put_rx_databuffer   = 1'b0;
    set_rd_req          = 1'b0;
    stop_det            = 1'b0;
    start_det           = 1'b0;
    slv_tx_chk_ack      = 1'b0;
    ack_det             = 1'b0;
    rdata_rx_databuffer = '0;
    repeat (5) @(posedge i2c_clk);
    #1;
    i2c_rst_n = 1'b1;
    tick(1);

    idle_after_reset();
    addr_then_writes();
    random_read();
    sequential_reads();
    partial_addr_read();
    stop_during_reads();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
